/* hdl/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    //////////////////////////////
    // instruction class

    localparam int ITYPE_NUM = 11;

    // bit positions inside the one-hot class vector
    typedef enum int unsigned {
        ITYPE_ALU   = 0,
        ITYPE_MUL   = 1,
        ITYPE_DIV   = 2,
        ITYPE_MEM   = 3,
        ITYPE_BR    = 4,
        ITYPE_BAR   = 5,
        ITYPE_CSR   = 6,
        ITYPE_CACHE = 7,
        ITYPE_TLB   = 8,
        ITYPE_IDLE  = 9,
        ITYPE_ERET  = 10
    } itype_e;

    // all zero means nop or invalid
    typedef logic [ITYPE_NUM-1:0] itype_t;

    //////////////////////////////
    // opcodes and operand sources

    // reg-reg codes equal inst[18:15]; sra sits on a free slot
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0010,
        ALU_SLT  = 4'b0100,
        ALU_SLTU = 4'b0101,
        ALU_NOR  = 4'b1000,
        ALU_AND  = 4'b1001,
        ALU_OR   = 4'b1010,
        ALU_XOR  = 4'b1011,
        ALU_SRA  = 4'b1100,
        ALU_SLL  = 4'b1110,
        ALU_SRL  = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RF    = 2'd0,
        SRC1_PC    = 2'd1,
        SRC1_ZERO  = 2'd2,
        SRC1_CNTID = 2'd3
    } src1_e;

    typedef enum logic [1:0] {
        SRC2_RF   = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_CNTL = 2'd2,
        SRC2_CNTH = 2'd3
    } src2_e;

    //////////////////////////////
    // exception codes

    localparam logic [6:0] EXC_NONE = 7'h00;
    localparam logic [6:0] EXC_SYS  = 7'h0b;
    localparam logic [6:0] EXC_BRK  = 7'h0c;
    localparam logic [6:0] EXC_INE  = 7'h0d;

    // andi r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    //////////////////////////////
    // buses

    // exc on top, inst at the bottom, 103 bits
    typedef struct packed {
        logic [6:0]  fetch_exc;
        logic [31:0] pc_next;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        itype_t      itype;
        src1_e       src1;
        src2_e       src2;
        logic        sign;
        logic        mem_atm;
        // alu op, mul/div variant, mem width or branch cond
        logic [3:0]  cond;
        logic [31:0] inst;
    } uop_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_next;
        uop_t        uop;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [6:0]  exc;
    } decoded_t;

endpackage

`default_nettype wire

/* hdl/decoder.sv */
`timescale 1ns/100ps
`default_nettype none

// loads, stores and branches read their rd-field source through rk,
// so the register file needs only the rj and rk read ports
module decoder
    import decode_pkg::*;
(
    input  fetch_entry_t entry,
    output decoded_t     dec,
    output logic         invalid_instruction,
    output logic         is_syscall,
    output logic         is_break
);

    logic [31:0] inst;
    itype_t      itype;
    logic        is_b_or_bl;
    logic        is_bl;
    logic        is_jirl;
    logic        is_preload;
    logic        is_pcadd;
    logic        is_lui;
    logic        is_alu_imm;
    logic        is_invtlb;
    logic        is_ecall;
    logic        is_alu_sfti;
    logic        is_sra;
    logic        is_time;
    logic        is_alu;
    logic        mem_write;
    logic        mem_atm;
    src1_e       src1;
    src2_e       src2;
    alu_op_e     alu_op;
    logic        alu_op_invalid;
    logic [3:0]  br_cond;
    logic        br_invalid;
    logic [3:0]  cond;
    logic        sign;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [31:0] imm;

    assign inst = entry.inst;

    //////////////////////////////
    // instruction class

    assign is_b_or_bl  = inst[30:27] == 4'b1010;
    assign is_bl       = inst[30:26] == 5'b10101;
    assign is_jirl     = inst[30:26] == 5'b10011;
    assign is_preload  = inst[30:22] == 9'b010101011;
    assign is_pcadd    = inst[30:25] == 6'b001110;
    assign is_lui      = inst[30:25] == 6'b001010;
    assign is_alu_imm  = inst[30:25] == 6'b000001;
    assign is_invtlb   = inst[30:15] == 16'b0000110010010011;
    assign is_ecall    = inst[30:17] == 14'b00000000010101 && !inst[15];
    assign is_alu_sfti = inst[30:20] == 11'b00000000100 && inst[17:15] == 3'b001;
    assign is_sra      = inst[30:15] == 16'b0000000000110000;
    assign is_time     = inst[30:11] == 20'b00000000000000001100;
    assign is_alu      = inst[30:19] == 12'b000000000010;

    assign is_syscall = is_ecall & inst[16];
    assign is_break   = is_ecall & ~inst[16];

    assign itype[ITYPE_BR]    = inst[30];
    assign itype[ITYPE_BAR]   = inst[30:16] == 15'b011100001110010;
    assign itype[ITYPE_MEM]   = inst[30:28] == 3'b010;
    assign itype[ITYPE_CSR]   = inst[30:24] == 7'b0000100;
    assign itype[ITYPE_CACHE] = inst[30:22] == 9'b000011000;
    assign itype[ITYPE_IDLE]  = inst[30:15] == 16'b0000110010010001;
    assign itype[ITYPE_ERET]  = inst[30:10] == 21'b000011001001000001110;
    // tlbsrch, tlbrd, tlbwr, tlbfill and invtlb
    assign itype[ITYPE_TLB]   = is_invtlb ||
        (inst[30:13] == 18'b000011001001000001 && inst[12:10] != 3'b110);
    assign itype[ITYPE_MUL]   = inst[30:17] == 14'b00000000001110;
    assign itype[ITYPE_DIV]   = inst[30:17] == 14'b00000000010000;
    assign itype[ITYPE_ALU]   = is_alu || is_time || is_sra || is_alu_sfti ||
        is_alu_imm || is_pcadd || is_lui;

    //////////////////////////////
    // operand sources

    always_comb begin
        if (is_lui) begin
            src1 = SRC1_ZERO;
        end else if (is_pcadd) begin
            src1 = SRC1_PC;
        end else if (is_time && !inst[10] && inst[4:0] == 5'd0) begin
            // rdcntid.w
            src1 = SRC1_CNTID;
        end else begin
            src1 = SRC1_RF;
        end
    end

    always_comb begin
        if (is_alu_imm || is_alu_sfti || is_lui || is_pcadd) begin
            src2 = SRC2_IMM;
        end else if (is_time) begin
            src2 = (!inst[10] && inst[4:0] != 5'd0) ? SRC2_CNTL : SRC2_CNTH;
        end else begin
            src2 = SRC2_RF;
        end
    end

    //////////////////////////////
    // alu op and branch condition

    always_comb begin
        alu_op         = ALU_ADD;
        alu_op_invalid = 1'b0;
        if (is_alu) begin
            alu_op = alu_op_e'(inst[18:15]);
        end else if (is_alu_imm) begin
            case (inst[24:22])
                3'b000:  alu_op = ALU_SLT;
                3'b001:  alu_op = ALU_SLTU;
                3'b010:  alu_op = ALU_ADD;
                3'b101:  alu_op = ALU_AND;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_XOR;
                default: alu_op_invalid = 1'b1;
            endcase
        end else if (is_alu_sfti) begin
            case (inst[19:18])
                2'b00:   alu_op = ALU_SLL;
                2'b01:   alu_op = ALU_SRL;
                2'b10:   alu_op = ALU_SRA;
                default: alu_op_invalid = 1'b1;
            endcase
        end else if (is_sra) begin
            alu_op = ALU_SRA;
        end
    end

    always_comb begin
        br_cond    = 4'd0;
        br_invalid = 1'b0;
        if (itype[ITYPE_BR]) begin
            br_cond = inst[29:26];
            // jirl, b, bl, beq, bne, blt, bge, bltu, bgeu
            if (inst[29:26] < 4'b0011 || inst[29:26] > 4'b1011) begin
                br_invalid = 1'b1;
            end
        end
    end

    // ll.w and sc.w have inst[27] low
    assign mem_atm   = ~inst[27];
    assign mem_write = itype[ITYPE_MEM] & inst[24];

    // unsigned mul/div on inst[16], unsigned loads on inst[25]
    assign sign = ((itype[ITYPE_MUL] | itype[ITYPE_DIV]) & ~inst[16]) |
                  (itype[ITYPE_MEM] & ~inst[25]);

    // atomics always move a full word
    assign cond = ({4{itype[ITYPE_ALU]}} & alu_op) |
        {3'b000, itype[ITYPE_DIV] & inst[15]} |
        {3'b000, itype[ITYPE_MUL] & (inst[15] | inst[16])} |
        ({4{itype[ITYPE_MEM]}} & {1'b0, inst[24], inst[27] ? inst[23:22] : 2'b10}) |
        ({4{itype[ITYPE_BR]}} & br_cond);

    assign invalid_instruction = alu_op_invalid || br_invalid || inst[31] ||
        (itype == '0 && !is_ecall);

    //////////////////////////////
    // register indices

    always_comb begin
        if (itype[ITYPE_CACHE] || itype[ITYPE_TLB] || itype[ITYPE_IDLE] ||
            itype[ITYPE_CSR] || is_preload || (mem_write && !mem_atm) ||
            (itype[ITYPE_BR] && !is_jirl && !is_bl)) begin
            rd = 5'd0;
        end else if (is_bl) begin
            // return address goes to r1
            rd = 5'd1;
        end else begin
            rd = inst[4:0];
        end
    end

    assign rj = (itype[ITYPE_CSR] || itype[ITYPE_TLB] || itype[ITYPE_IDLE] ||
                 is_pcadd || is_lui || is_b_or_bl) ? 5'd0 : inst[9:5];

    always_comb begin
        if (is_alu || is_sra || itype[ITYPE_MUL] || itype[ITYPE_DIV]) begin
            rk = inst[14:10];
        end else if (mem_write || (itype[ITYPE_BR] && !is_b_or_bl && !is_jirl)) begin
            // store data or second compare operand
            rk = inst[4:0];
        end else begin
            rk = 5'd0;
        end
    end

    //////////////////////////////
    // immediate

    // shift amounts ride in the low bits of the i12 field
    always_comb begin
        imm = '0;
        if (itype[ITYPE_CACHE] || (is_alu_imm && !inst[24]) ||
            (itype[ITYPE_MEM] && inst[27]) || is_alu_sfti) begin
            imm = imm | {{20{inst[21]}}, inst[21:10]};
        end
        if (is_alu_imm && inst[24]) begin
            imm = imm | {20'd0, inst[21:10]};
        end
        if ((itype[ITYPE_MEM] && !inst[27]) || itype[ITYPE_CSR]) begin
            imm = imm | {{18{inst[23]}}, inst[23:10]};
        end
        if (itype[ITYPE_BR] && !is_b_or_bl) begin
            imm = imm | {{16{inst[25]}}, inst[25:10]};
        end
        if (is_b_or_bl) begin
            imm = imm | {{6{inst[9]}}, inst[9:0], inst[25:10]};
        end
        if (is_pcadd || is_lui) begin
            imm = imm | {inst[24:5], 12'd0};
        end
    end

    //////////////////////////////
    // output bundle

    always_comb begin
        dec              = '0;
        dec.pc           = entry.pc;
        dec.pc_next      = entry.pc_next;
        dec.uop.itype    = (inst == INST_NOP || invalid_instruction) ? '0 : itype;
        dec.uop.src1     = src1;
        dec.uop.src2     = src2;
        dec.uop.sign     = sign;
        dec.uop.mem_atm  = mem_atm;
        dec.uop.cond     = cond;
        dec.uop.inst     = inst;
        dec.imm          = imm;
        dec.rd           = rd;
        dec.rj           = rj;
        dec.rk           = rk;
        dec.exc          = entry.fetch_exc;
    end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     stall,
    input  logic     flush,
    input  decoded_t dec,
    input  logic     invalid_instruction,
    input  logic     is_syscall,
    input  logic     is_break,
    output logic     out_valid,
    output decoded_t out
);

    decoded_t merged;

    //////////////////////////////
    // exception merge

    // fetch exceptions are older and win
    always_comb begin
        merged = dec;
        if (dec.exc == EXC_NONE) begin
            if (invalid_instruction) begin
                merged.exc = EXC_INE;
            end else if (is_syscall) begin
                merged.exc = EXC_SYS;
            end else if (is_break) begin
                merged.exc = EXC_BRK;
            end
        end
    end

    //////////////////////////////
    // pipeline register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            // flush beats stall
            if (flush) begin
                out_valid <= 1'b0;
            end else if (!stall) begin
                out_valid <= in_valid;
            end
            if (!stall) begin
                out <= merged;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_top
    import decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  fetch_entry_t entry,
    input  logic         stall,
    input  logic         flush,
    output logic         out_valid,
    output decoded_t     out
);

    decoded_t dec;
    logic     invalid_instruction;
    logic     is_syscall;
    logic     is_break;

    // combinational decode
    decoder decoder_i (
        .entry               (entry),
        .dec                 (dec),
        .invalid_instruction (invalid_instruction),
        .is_syscall          (is_syscall),
        .is_break            (is_break)
    );

    // one cycle register toward issue
    decode_stage decode_stage_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .in_valid            (in_valid),
        .stall               (stall),
        .flush               (flush),
        .dec                 (dec),
        .invalid_instruction (invalid_instruction),
        .is_syscall          (is_syscall),
        .is_break            (is_break),
        .out_valid           (out_valid),
        .out                 (out)
    );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

// 100 ns clock, reset held low for the first two rising edges
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* tests/decode_props.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_props
    import decode_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     stall,
    input logic     flush,
    input logic     out_valid,
    input decoded_t out
);

    // slot is empty while reset is held
    reset_empty: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid)
        else $error("out_valid still high after flush");

    // stall alone freezes the register
    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> ($stable(out) && $stable(out_valid)))
        else $error("stage output changed during stall");

endmodule

bind decode_stage decode_props props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .flush     (flush),
    .out_valid (out_valid),
    .out       (out)
);

`default_nettype wire

/* tests/decode_checker.sv */
`timescale 1ns/100ps
`default_nettype none

// compares the registered DUT output one cycle after the inputs
module decode_checker
    import decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         check_en,
    input  logic [127:0] tag,
    input  logic         exp_valid,
    input  logic [10:0]  exp_itype,
    input  logic [3:0]   exp_cond,
    input  logic [4:0]   exp_rd,
    input  logic [4:0]   exp_rj,
    input  logic [4:0]   exp_rk,
    input  logic [31:0]  exp_imm,
    input  logic [6:0]   exp_exc,
    input  logic [31:0]  exp_pc,
    input  logic [31:0]  exp_inst,
    input  logic         out_valid,
    input  decoded_t     out,
    output int           test_count,
    output int           fail_count
);

    logic         pend_en;
    logic [127:0] pend_tag;
    logic         pend_valid;
    logic [10:0]  pend_itype;
    logic [3:0]   pend_cond;
    logic [4:0]   pend_rd;
    logic [4:0]   pend_rj;
    logic [4:0]   pend_rk;
    logic [31:0]  pend_imm;
    logic [6:0]   pend_exc;
    logic [31:0]  pend_pc;
    logic [31:0]  pend_inst;

    function automatic int field_differs(input string name, input logic [31:0] got,
                                         input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %0s %0s got 0x%0h expected 0x%0h", pend_tag, name, got, want);
            return 1;
        end
        return 0;
    endfunction

    //////////////////////////////
    // expected values follow the DUT register by one edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_en    <= 1'b0;
            pend_tag   <= '0;
            pend_valid <= 1'b0;
            pend_itype <= '0;
            pend_cond  <= '0;
            pend_rd    <= '0;
            pend_rj    <= '0;
            pend_rk    <= '0;
            pend_imm   <= '0;
            pend_exc   <= '0;
            pend_pc    <= '0;
            pend_inst  <= '0;
        end else begin
            pend_en    <= check_en;
            pend_tag   <= tag;
            pend_valid <= exp_valid;
            pend_itype <= exp_itype;
            pend_cond  <= exp_cond;
            pend_rd    <= exp_rd;
            pend_rj    <= exp_rj;
            pend_rk    <= exp_rk;
            pend_imm   <= exp_imm;
            pend_exc   <= exp_exc;
            pend_pc    <= exp_pc;
            pend_inst  <= exp_inst;
        end
    end

    initial begin
        test_count = 0;
        fail_count = 0;
    end

    // sample mid cycle, away from the driving edge
    always @(negedge clk) begin
        int errs;
        errs = 0;
        if (rst_n && pend_en) begin
            errs += field_differs("out_valid", 32'(out_valid), 32'(pend_valid));
            // fields only matter for a valid slot
            if (pend_valid) begin
                errs += field_differs("itype", 32'(out.uop.itype), 32'(pend_itype));
                errs += field_differs("cond", 32'(out.uop.cond), 32'(pend_cond));
                errs += field_differs("rd", 32'(out.rd), 32'(pend_rd));
                errs += field_differs("rj", 32'(out.rj), 32'(pend_rj));
                errs += field_differs("rk", 32'(out.rk), 32'(pend_rk));
                errs += field_differs("imm", out.imm, pend_imm);
                errs += field_differs("exc", 32'(out.exc), 32'(pend_exc));
                errs += field_differs("pc", out.pc, pend_pc);
                errs += field_differs("pc_next", out.pc_next, pend_pc + 32'd4);
                errs += field_differs("inst", out.uop.inst, pend_inst);
            end
            test_count++;
            if (errs != 0) begin
                fail_count++;
                $display("bad  %0s (%0d fields wrong)", pend_tag, errs);
            end else begin
                $display("ok   %0s", pend_tag);
            end
        end
    end

endmodule

`default_nettype wire

/* tests/decode_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_tb
    import decode_pkg::*;
();

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         stall;
    logic         flush;
    fetch_entry_t entry;
    logic         out_valid;
    decoded_t     out;

    logic         check_en;
    logic [127:0] tag_w;
    logic         exp_valid;
    logic [10:0]  exp_itype;
    logic [3:0]   exp_cond;
    logic [4:0]   exp_rd;
    logic [4:0]   exp_rj;
    logic [4:0]   exp_rk;
    logic [31:0]  exp_imm;
    logic [6:0]   exp_exc;
    logic [31:0]  exp_pc;
    logic [31:0]  exp_inst;
    int           test_count;
    int           fail_count;

    tb_clock clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .entry     (entry),
        .stall     (stall),
        .flush     (flush),
        .out_valid (out_valid),
        .out       (out)
    );

    decode_checker checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .check_en   (check_en),
        .tag        (tag_w),
        .exp_valid  (exp_valid),
        .exp_itype  (exp_itype),
        .exp_cond   (exp_cond),
        .exp_rd     (exp_rd),
        .exp_rj     (exp_rj),
        .exp_rk     (exp_rk),
        .exp_imm    (exp_imm),
        .exp_exc    (exp_exc),
        .exp_pc     (exp_pc),
        .exp_inst   (exp_inst),
        .out_valid  (out_valid),
        .out        (out),
        .test_count (test_count),
        .fail_count (fail_count)
    );

    initial begin
        int           fd;
        int           n_vec;
        int           bad_lines;
        int           cycles;
        int           nread;
        logic         aborted;
        string        line;
        logic [127:0] tag;
        logic [31:0]  v, s, f, inst, pc, fexc, ev;
        logic [31:0]  itype, cond, rd, rj, rk, imm, exc;

        in_valid  = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        entry     = '0;
        check_en  = 1'b0;
        tag_w     = '0;
        exp_valid = 1'b0;
        exp_itype = '0;
        exp_cond  = '0;
        exp_rd    = '0;
        exp_rj    = '0;
        exp_rk    = '0;
        exp_imm   = '0;
        exp_exc   = '0;
        exp_pc    = '0;
        exp_inst  = '0;
        aborted   = 1'b0;
        n_vec     = 0;
        bad_lines = 0;
        fd        = 0;

        //////////////////////////////
        // reset release

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            aborted = 1'b1;
        end

        if (!aborted) begin
            fd = $fopen("tests/decode_stimulus.txt", "r");
            if (fd == 0) begin
                $display("could not open the stimulus file");
                aborted = 1'b1;
            end
        end

        //////////////////////////////
        // one vector per cycle

        if (!aborted) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != 8'h23) begin
                    nread = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                    tag, v, s, f, inst, pc, fexc, ev,
                                    itype, cond, rd, rj, rk, imm, exc);
                    if (nread != 15) begin
                        bad_lines++;
                        $display("could not parse stimulus line: %0s", line);
                    end else begin
                        @(posedge clk);
                        in_valid        <= v[0];
                        stall           <= s[0];
                        flush           <= f[0];
                        entry.inst      <= inst;
                        entry.pc        <= pc;
                        entry.pc_next   <= pc + 32'd4;
                        entry.fetch_exc <= fexc[6:0];
                        check_en        <= 1'b1;
                        tag_w           <= tag;
                        exp_valid       <= ev[0];
                        exp_itype       <= itype[10:0];
                        exp_cond        <= cond[3:0];
                        exp_rd          <= rd[4:0];
                        exp_rj          <= rj[4:0];
                        exp_rk          <= rk[4:0];
                        exp_imm         <= imm;
                        exp_exc         <= exc[6:0];
                        // a stalled slot keeps the entry it already holds
                        if (!s[0]) begin
                            exp_pc   <= pc;
                            exp_inst <= inst;
                        end
                        n_vec++;
                    end
                end
            end
            $fclose(fd);

            @(posedge clk);
            in_valid <= 1'b0;
            stall    <= 1'b0;
            flush    <= 1'b0;
            check_en <= 1'b0;

            // drain the last result
            cycles = 0;
            while (test_count < n_vec && cycles < 10) begin
                @(posedge clk);
                cycles++;
            end
            if (test_count < n_vec) begin
                $display("timed out waiting for the last results");
                aborted = 1'b1;
            end
        end

        $display("%0d tests run, %0d failed, %0d bad stimulus lines",
                 test_count, fail_count, bad_lines);
        if (!aborted && bad_lines == 0 && fail_count == 0 && n_vec > 0 &&
            test_count == n_vec) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/decode_stimulus.txt */
# tag in_valid stall flush inst pc fetch_exc | exp: out_valid itype cond rd rj rk imm exc
# all values hex; stalled rows expect the previous output held
add_w         1 0 0 00101483 1c000000 00 1 001 0 03 04 05 00000000 00
sub_w         1 0 0 001120e6 1c000004 00 1 001 2 06 07 08 00000000 00
sra_w         1 0 0 00182d49 1c000008 00 1 001 c 09 0a 0b 00000000 00
addi_w        1 0 0 02bff041 1c00000c 00 1 001 0 01 02 00 fffffffc 00
ori           1 0 0 03a000c5 1c000010 00 1 001 a 05 06 00 00000800 00
ll_w          1 0 0 20ffe1ac 1c000014 00 1 008 2 0c 0d 00 fffffff8 00
lu12i_w       1 0 0 15000027 1c000018 00 1 001 0 07 00 00 80001000 00
beq           1 0 0 58004085 1c00001c 00 1 010 6 00 04 05 00000010 00
bl            1 0 0 57fffbff 1c000020 00 1 010 5 01 00 00 fffffffe 00
jirl          1 0 0 4c001041 1c000024 00 1 010 3 01 02 00 00000004 00
bit31_ine     1 0 0 80101483 1c000028 00 1 000 0 03 04 05 00000000 0d
alui_ine      1 0 0 02c00041 1c00002c 00 1 000 0 01 02 00 00000000 0d
syscall       1 0 0 002b0000 1c000030 00 1 000 0 00 00 00 00000000 0b
break         1 0 0 002a0000 1c000034 00 1 000 0 00 00 00 00000000 0c
fetch_exc     1 0 0 80000000 1c000038 08 1 000 0 00 00 00 00000000 08
stall_hold    1 1 0 00101483 1c00003c 00 1 000 0 00 00 00 00000000 08
stall_release 1 0 0 00101483 1c00003c 00 1 001 0 03 04 05 00000000 00
flush         1 0 1 001120e6 1c000040 00 0 000 0 00 00 00 00000000 00
no_valid      0 0 0 00182d49 1c000044 00 0 000 0 00 00 00 00000000 00
resume        1 0 0 00182d49 1c000044 00 1 001 c 09 0a 0b 00000000 00

/* filelist.f */
hdl/decode_pkg.sv
hdl/decoder.sv
hdl/decode_stage.sv
hdl/decode_top.sv
tests/tb_clock.sv
tests/decode_props.sv
tests/decode_checker.sv
tests/decode_tb.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module decode_tb \
    -f filelist.f -o decode_sim > build.log 2>&1 &&
./obj_dir/decode_sim > sim.log 2>&1 ||
{ echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
